// ==== source/axi_spi_pkg.sv ====
package axi_spi_pkg;

  localparam int AXI_DATA_W = 32;
  localparam int AXI_ADDR_W = 8;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  typedef logic [AXI_DATA_W-1:0] axi_word_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [1:0]            axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // register map, decoded on bits 7..2
  localparam axi_addr_t ADDR_SRR  = 8'h40;
  localparam axi_addr_t ADDR_CR   = 8'h60;
  localparam axi_addr_t ADDR_SR   = 8'h64;
  localparam axi_addr_t ADDR_DTR  = 8'h68;
  localparam axi_addr_t ADDR_DRR  = 8'h6C;
  localparam axi_addr_t ADDR_SSR  = 8'h70;
  localparam axi_addr_t ADDR_TFOR = 8'h74;
  localparam axi_addr_t ADDR_RFOR = 8'h78;
  localparam axi_addr_t ADDR_RCLK = 8'h80; // custom clock ratio

  localparam axi_word_t SRR_KEY            = 32'h0000_000A;
  localparam axi_word_t REG_UNMAPPED_VALUE = 32'h6162_6364;

  localparam int SR_RX_EMPTY_BIT = 0;
  localparam int SR_RX_FULL_BIT  = 1;
  localparam int SR_TX_EMPTY_BIT = 2;
  localparam int SR_TX_FULL_BIT  = 3;

  typedef struct packed {
    logic [21:0] reserved;
    logic        lsb_first;     // bit 9
    logic [1:0]  reserved_8_7;
    logic        rx_fifo_reset; // self clearing
    logic        tx_fifo_reset; // self clearing
    logic        cpha;
    logic        cpol;
    logic        master;
    logic        spe;
    logic        loop;          // not implemented
  } spi_cr_fields_t;

  typedef union packed {
    axi_word_t      word;
    spi_cr_fields_t f;
  } spi_cr_u;

  localparam axi_word_t CR_INIT   = 32'h0000_0000;
  localparam axi_word_t SSR_INIT  = 32'h0000_0001;
  localparam axi_word_t RCLK_INIT = 32'h0000_0000;

endpackage

// ==== source/axi_spi_wr_ctrl.sv ====
`timescale 1ns/1ps

module axi_spi_wr_ctrl #(
  parameter int DATA_WIDTH  = 8,
  parameter int RATIO_WIDTH = 3
) (
  input  logic                               fixed_clk_i,
  input  logic                               axi_aresetn_i,
  input  axi_spi_pkg::axi_addr_t             axi_awaddr_i,
  input  logic                               axi_awvalid_i,
  output logic                               axi_awready_o,
  input  axi_spi_pkg::axi_word_t             axi_wdata_i,
  input  logic [axi_spi_pkg::AXI_STRB_W-1:0] axi_wstrb_i,
  input  logic                               axi_wvalid_i,
  output logic                               axi_wready_o,
  output axi_spi_pkg::axi_resp_t             axi_bresp_o,
  output logic                               axi_bvalid_o,
  input  logic                               axi_bready_i,
  input  logic                               tx_full_i,
  output axi_spi_pkg::spi_cr_u               control_o,
  output logic                               slave_select_o,
  output logic [RATIO_WIDTH-1:0]             ratio_o,
  output logic                               tx_push_o,
  output logic [DATA_WIDTH-1:0]              tx_push_data_o,
  output logic                               tx_clr_o,
  output logic                               rx_clr_o,
  output logic                               soft_rst_o
);
  import axi_spi_pkg::*;

  typedef enum logic [1:0] {WR_IDLE, WR_ACK, WR_RESP} wr_state_e;

  wr_state_e             state_q;
  axi_word_t             wdata_m;
  spi_cr_u               cr_wr;
  logic [AXI_ADDR_W-3:0] reg_sel;
  logic                  wr_fire;
  logic                  sel_srr;
  logic                  sel_cr;
  logic                  sel_dtr;
  logic                  sel_ssr;
  logic                  sel_rclk;

  always_comb begin
    for (int i = 0; i < AXI_STRB_W; i++) begin
      wdata_m[8*i +: 8] = axi_wstrb_i[i] ? axi_wdata_i[8*i +: 8] : 8'h00; // unstrobed byte is zero
    end
  end

  assign cr_wr.word = wdata_m;
  assign reg_sel    = axi_awaddr_i[AXI_ADDR_W-1:2];
  assign sel_srr    = (reg_sel == ADDR_SRR[AXI_ADDR_W-1:2]);
  assign sel_cr     = (reg_sel == ADDR_CR[AXI_ADDR_W-1:2]);
  assign sel_dtr    = (reg_sel == ADDR_DTR[AXI_ADDR_W-1:2]);
  assign sel_ssr    = (reg_sel == ADDR_SSR[AXI_ADDR_W-1:2]);
  assign sel_rclk   = (reg_sel == ADDR_RCLK[AXI_ADDR_W-1:2]);

  assign wr_fire       = (state_q == WR_ACK); // handshake cycle
  assign axi_awready_o = wr_fire;
  assign axi_wready_o  = wr_fire;
  assign axi_bvalid_o  = (state_q != WR_IDLE);
  assign axi_bresp_o   = RESP_OKAY;

  // one-cycle strobes, issued with awready
  assign tx_push_o      = wr_fire & sel_dtr;
  assign tx_push_data_o = wdata_m[DATA_WIDTH-1:0];
  assign tx_clr_o       = wr_fire & sel_cr & cr_wr.f.tx_fifo_reset;
  assign rx_clr_o       = wr_fire & sel_cr & cr_wr.f.rx_fifo_reset;
  assign soft_rst_o     = wr_fire & sel_srr & (wdata_m == SRR_KEY);

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state_q        <= WR_IDLE;
      control_o.word <= CR_INIT;
      slave_select_o <= SSR_INIT[0];
      ratio_o        <= RCLK_INIT[RATIO_WIDTH-1:0];
    end else begin
      case (state_q)
        WR_IDLE: begin
          // dtr write stalls while the tx fifo is full
          if (axi_awvalid_i && axi_wvalid_i && !(sel_dtr && tx_full_i)) begin
            state_q <= WR_ACK;
          end
        end
        WR_ACK: state_q <= axi_bready_i ? WR_IDLE : WR_RESP;
        default: begin
          if (axi_bready_i) begin
            state_q <= WR_IDLE;
          end
        end
      endcase

      if (soft_rst_o) begin
        control_o.word <= CR_INIT;
        slave_select_o <= SSR_INIT[0];
        ratio_o        <= RCLK_INIT[RATIO_WIDTH-1:0];
      end else if (wr_fire) begin
        if (sel_cr) begin
          control_o.word            <= cr_wr.word;
          control_o.f.tx_fifo_reset <= 1'b0; // reset bits never stored
          control_o.f.rx_fifo_reset <= 1'b0;
        end
        if (sel_ssr) begin
          slave_select_o <= wdata_m[0];
        end
        if (sel_rclk) begin
          ratio_o <= wdata_m[RATIO_WIDTH-1:0];
        end
      end
    end
  end

endmodule

// ==== source/axi_spi_rd_ctrl.sv ====
`timescale 1ns/1ps

module axi_spi_rd_ctrl #(
  parameter int DATA_WIDTH  = 8,
  parameter int FIFO_DEPTH  = 16,
  parameter int RATIO_WIDTH = 3
) (
  input  logic                             fixed_clk_i,
  input  logic                             axi_aresetn_i,
  input  axi_spi_pkg::axi_addr_t           axi_araddr_i,
  input  logic                             axi_arvalid_i,
  output logic                             axi_arready_o,
  output axi_spi_pkg::axi_word_t           axi_rdata_o,
  output axi_spi_pkg::axi_resp_t           axi_rresp_o,
  output logic                             axi_rvalid_o,
  input  logic                             axi_rready_i,
  input  axi_spi_pkg::spi_cr_u             control_i,
  input  logic                             slave_select_i,
  input  logic [RATIO_WIDTH-1:0]           ratio_i,
  input  axi_spi_pkg::axi_word_t           status_i,
  input  logic                             rx_empty_i,
  input  logic [DATA_WIDTH-1:0]            rx_data_i,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0]  tx_count_i,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0]  rx_count_i,
  output logic                             rx_pop_o
);
  import axi_spi_pkg::*;

  typedef enum logic [1:0] {RD_IDLE, RD_ACK, RD_RESP} rd_state_e;

  rd_state_e             state_q;
  logic [AXI_ADDR_W-3:0] reg_sel;
  logic                  sel_drr;
  logic                  rd_start;
  axi_word_t             rd_word;

  assign reg_sel  = axi_araddr_i[AXI_ADDR_W-1:2];
  assign sel_drr  = (reg_sel == ADDR_DRR[AXI_ADDR_W-1:2]);
  assign rd_start = (state_q == RD_IDLE) & axi_arvalid_i & ~(sel_drr & rx_empty_i);

  always_comb begin
    case (reg_sel)
      ADDR_CR[AXI_ADDR_W-1:2]:   rd_word = control_i.word;
      ADDR_SR[AXI_ADDR_W-1:2]:   rd_word = status_i;
      ADDR_DTR[AXI_ADDR_W-1:2]:  rd_word = '0; // write only
      ADDR_DRR[AXI_ADDR_W-1:2]:  rd_word = axi_word_t'(rx_data_i);
      ADDR_SSR[AXI_ADDR_W-1:2]:  rd_word = axi_word_t'(slave_select_i);
      ADDR_TFOR[AXI_ADDR_W-1:2]: rd_word = axi_word_t'(tx_count_i);
      ADDR_RFOR[AXI_ADDR_W-1:2]: rd_word = axi_word_t'(rx_count_i);
      ADDR_RCLK[AXI_ADDR_W-1:2]: rd_word = axi_word_t'(ratio_i);
      default:                   rd_word = REG_UNMAPPED_VALUE; // includes srr
    endcase
  end

  assign axi_arready_o = (state_q == RD_ACK);
  assign axi_rvalid_o  = (state_q != RD_IDLE);
  assign axi_rresp_o   = RESP_OKAY;
  assign rx_pop_o      = (state_q == RD_ACK) & sel_drr; // head already latched

  always_ff @(posedge fixed_clk_i) begin
    if (rd_start) begin
      axi_rdata_o <= rd_word;
    end
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state_q <= RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (rd_start) begin
            state_q <= RD_ACK;
          end
        end
        RD_ACK: state_q <= axi_rready_i ? RD_IDLE : RD_RESP;
        default: begin
          if (axi_rready_i) begin
            state_q <= RD_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// ==== source/spi_fifo.sv ====
`timescale 1ns/1ps

module spi_fifo #(
  parameter int DATA_WIDTH = 8,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                            fixed_clk_i,
  input  logic                            axi_aresetn_i,
  input  logic                            soft_rst_i,
  input  logic                            clr_i,
  input  logic                            push_i,
  input  logic [DATA_WIDTH-1:0]           push_data_i,
  input  logic                            pop_i,
  output logic [DATA_WIDTH-1:0]           pop_data_o,
  output logic                            empty_o,
  output logic                            full_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] count_o
);
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic                  do_push;
  logic                  do_pop;

  assign do_push    = push_i & ~full_o; // push on full dropped
  assign do_pop     = pop_i & ~empty_o;
  assign empty_o    = (count_o == '0);
  assign full_o     = (count_o == CNT_W'(FIFO_DEPTH));
  assign pop_data_o = mem[rd_ptr];

  always_ff @(posedge fixed_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else if (soft_rst_i || clr_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      wr_ptr  <= wr_ptr + PTR_W'(do_push); // wraps at depth
      rd_ptr  <= rd_ptr + PTR_W'(do_pop);
      count_o <= count_o + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

endmodule

// ==== source/spi_shifter.sv ====
`timescale 1ns/1ps

module spi_shifter #(
  parameter int DATA_WIDTH  = 8,
  parameter int RATIO_WIDTH = 3
) (
  input  logic                   fixed_clk_i,
  input  logic                   axi_aresetn_i,
  input  logic                   soft_rst_i,
  input  axi_spi_pkg::spi_cr_u   control_i,
  input  logic                   slave_select_i,
  input  logic [RATIO_WIDTH-1:0] ratio_i,
  input  logic                   tx_valid_i,
  input  logic [DATA_WIDTH-1:0]  tx_data_i,
  output logic                   tx_pop_o,
  input  logic                   rx_ready_i,
  output logic                   rx_push_o,
  output logic [DATA_WIDTH-1:0]  rx_data_o,
  output logic                   spi_clk_o,
  output logic                   spi_cs_n_o,
  output logic                   spi_mosi_o,
  input  logic                   spi_miso_i
);
  localparam int DIV_W  = 2 ** RATIO_WIDTH;
  localparam int EDGE_W = $clog2(2 * DATA_WIDTH);

  typedef enum logic [1:0] {SH_IDLE, SH_BUSY, SH_DONE} sh_state_e;

  sh_state_e             state_q;
  logic [DIV_W-1:0]      div_cnt;
  logic [EDGE_W-1:0]     edge_cnt;  // sclk edges within a word
  logic [DATA_WIDTH-1:0] tx_sr;
  logic                  start;
  logic                  div_last;
  logic                  sample_edge;
  logic                  shift_edge;

  // full rx fifo holds off the next word
  assign start = (state_q == SH_IDLE) & control_i.f.spe & control_i.f.master &
                 tx_valid_i & rx_ready_i;

  assign div_last    = (div_cnt == (DIV_W'(1) << ratio_i) - DIV_W'(1));
  assign sample_edge = div_last & (edge_cnt[0] == control_i.f.cpha);
  assign shift_edge  = div_last & (edge_cnt[0] != control_i.f.cpha) & (edge_cnt != '0);

  assign tx_pop_o   = start;
  assign rx_push_o  = (state_q == SH_DONE);
  assign spi_mosi_o = control_i.f.lsb_first ? tx_sr[0] : tx_sr[DATA_WIDTH-1];
  assign spi_cs_n_o = ~((state_q == SH_BUSY) & control_i.f.spe & ~slave_select_i);

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state_q   <= SH_IDLE;
      div_cnt   <= '0;
      edge_cnt  <= '0;
      tx_sr     <= '0;
      rx_data_o <= '0;
      spi_clk_o <= 1'b0;
    end else if (soft_rst_i) begin
      state_q   <= SH_IDLE;
      spi_clk_o <= 1'b0; // cr returns to zero with the soft reset
    end else begin
      case (state_q)
        SH_IDLE: begin
          spi_clk_o <= control_i.f.cpol; // idle level
          div_cnt   <= '0;
          edge_cnt  <= '0;
          if (start) begin
            tx_sr   <= tx_data_i;
            state_q <= SH_BUSY;
          end
        end
        SH_BUSY: begin
          div_cnt <= div_last ? '0 : div_cnt + 1'b1;
          if (div_last) begin
            spi_clk_o <= ~spi_clk_o;
            edge_cnt  <= edge_cnt + 1'b1;
          end
          if (sample_edge) begin
            rx_data_o <= control_i.f.lsb_first ? {spi_miso_i, rx_data_o[DATA_WIDTH-1:1]}
                                               : {rx_data_o[DATA_WIDTH-2:0], spi_miso_i};
          end
          if (shift_edge) begin
            tx_sr <= control_i.f.lsb_first ? (tx_sr >> 1) : (tx_sr << 1);
          end
          if (!control_i.f.spe) begin
            state_q <= SH_IDLE; // abort, word is dropped
          end else if (div_last && edge_cnt == EDGE_W'(2 * DATA_WIDTH - 1)) begin
            state_q <= SH_DONE;
          end
        end
        default: state_q <= SH_IDLE; // push cycle
      endcase
    end
  end

endmodule

// ==== source/spi_core.sv ====
`timescale 1ns/1ps

module spi_core #(
  parameter int DATA_WIDTH  = 8,
  parameter int FIFO_DEPTH  = 16,
  parameter int RATIO_WIDTH = 3
) (
  input  logic                            fixed_clk_i,
  input  logic                            axi_aresetn_i,
  input  logic                            soft_rst_i,
  input  axi_spi_pkg::spi_cr_u            control_i,
  input  logic                            slave_select_i,
  input  logic [RATIO_WIDTH-1:0]          ratio_i,
  input  logic                            tx_push_i,
  input  logic [DATA_WIDTH-1:0]           tx_push_data_i,
  input  logic                            tx_clr_i,
  input  logic                            rx_pop_i,
  input  logic                            rx_clr_i,
  output axi_spi_pkg::axi_word_t          status_o,
  output logic                            tx_full_o,
  output logic                            rx_empty_o,
  output logic [DATA_WIDTH-1:0]           rx_data_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] tx_count_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] rx_count_o,
  output logic                            spi_clk_o,
  output logic                            spi_cs_n_o,
  output logic                            spi_mosi_o,
  input  logic                            spi_miso_i
);
  import axi_spi_pkg::*;

  logic                  tx_empty;
  logic                  tx_pop;
  logic [DATA_WIDTH-1:0] tx_head;
  logic                  rx_full;
  logic                  rx_push;
  logic [DATA_WIDTH-1:0] rx_word;

  always_comb begin
    status_o                  = '0; // slave mode bits read zero
    status_o[SR_RX_EMPTY_BIT] = rx_empty_o;
    status_o[SR_RX_FULL_BIT]  = rx_full;
    status_o[SR_TX_EMPTY_BIT] = tx_empty;
    status_o[SR_TX_FULL_BIT]  = tx_full_o;
  end

  spi_fifo #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) tx_fifo_i (
    .fixed_clk_i, .axi_aresetn_i, .soft_rst_i,
    .clr_i       (tx_clr_i),
    .push_i      (tx_push_i),
    .push_data_i (tx_push_data_i),
    .pop_i       (tx_pop),
    .pop_data_o  (tx_head),
    .empty_o     (tx_empty),
    .full_o      (tx_full_o),
    .count_o     (tx_count_o)
  );

  spi_fifo #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) rx_fifo_i (
    .fixed_clk_i, .axi_aresetn_i, .soft_rst_i,
    .clr_i       (rx_clr_i),
    .push_i      (rx_push),
    .push_data_i (rx_word),
    .pop_i       (rx_pop_i),
    .pop_data_o  (rx_data_o),
    .empty_o     (rx_empty_o),
    .full_o      (rx_full),
    .count_o     (rx_count_o)
  );

  spi_shifter #(.DATA_WIDTH(DATA_WIDTH), .RATIO_WIDTH(RATIO_WIDTH)) shifter_i (
    .fixed_clk_i, .axi_aresetn_i, .soft_rst_i, .control_i, .slave_select_i, .ratio_i,
    .tx_valid_i (~tx_empty),
    .tx_data_i  (tx_head),
    .tx_pop_o   (tx_pop),
    .rx_ready_i (~rx_full),
    .rx_push_o  (rx_push),
    .rx_data_o  (rx_word),
    .spi_clk_o, .spi_cs_n_o, .spi_mosi_o, .spi_miso_i
  );

endmodule

// ==== source/axi_spi_top.sv ====
`timescale 1ns/1ps

module axi_spi_top #(
  parameter int DATA_WIDTH  = 8,
  parameter int FIFO_DEPTH  = 16,
  parameter int RATIO_WIDTH = 3
) (
  input  logic                               fixed_clk_i,
  input  logic                               axi_aresetn_i,
  input  axi_spi_pkg::axi_addr_t             axi_awaddr_i,
  input  logic                               axi_awvalid_i,
  output logic                               axi_awready_o,
  input  axi_spi_pkg::axi_word_t             axi_wdata_i,
  input  logic [axi_spi_pkg::AXI_STRB_W-1:0] axi_wstrb_i,
  input  logic                               axi_wvalid_i,
  output logic                               axi_wready_o,
  output axi_spi_pkg::axi_resp_t             axi_bresp_o,
  output logic                               axi_bvalid_o,
  input  logic                               axi_bready_i,
  input  axi_spi_pkg::axi_addr_t             axi_araddr_i,
  input  logic                               axi_arvalid_i,
  output logic                               axi_arready_o,
  output axi_spi_pkg::axi_word_t             axi_rdata_o,
  output axi_spi_pkg::axi_resp_t             axi_rresp_o,
  output logic                               axi_rvalid_o,
  input  logic                               axi_rready_i,
  output logic                               spi_clk_o,
  output logic                               spi_cs_n_o,
  output logic                               spi_mosi_o,
  input  logic                               spi_miso_i
);
  import axi_spi_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  spi_cr_u               control;
  logic                  slave_select;
  logic [RATIO_WIDTH-1:0] ratio;
  logic                  tx_push;
  logic [DATA_WIDTH-1:0] tx_push_data;
  logic                  tx_clr;
  logic                  rx_clr;
  logic                  soft_rst;
  logic                  rx_pop;
  axi_word_t             status;
  logic                  tx_full;
  logic                  rx_empty;
  logic [DATA_WIDTH-1:0] rx_data;
  logic [CNT_W-1:0]      tx_count;
  logic [CNT_W-1:0]      rx_count;

  axi_spi_wr_ctrl #(.DATA_WIDTH(DATA_WIDTH), .RATIO_WIDTH(RATIO_WIDTH)) wr_ctrl_i (
    .fixed_clk_i, .axi_aresetn_i,
    .axi_awaddr_i, .axi_awvalid_i, .axi_awready_o,
    .axi_wdata_i, .axi_wstrb_i, .axi_wvalid_i, .axi_wready_o,
    .axi_bresp_o, .axi_bvalid_o, .axi_bready_i,
    .tx_full_i      (tx_full),
    .control_o      (control),
    .slave_select_o (slave_select),
    .ratio_o        (ratio),
    .tx_push_o      (tx_push),
    .tx_push_data_o (tx_push_data),
    .tx_clr_o       (tx_clr),
    .rx_clr_o       (rx_clr),
    .soft_rst_o     (soft_rst)
  );

  axi_spi_rd_ctrl #(
    .DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH), .RATIO_WIDTH(RATIO_WIDTH)
  ) rd_ctrl_i (
    .fixed_clk_i, .axi_aresetn_i,
    .axi_araddr_i, .axi_arvalid_i, .axi_arready_o,
    .axi_rdata_o, .axi_rresp_o, .axi_rvalid_o, .axi_rready_i,
    .control_i      (control),
    .slave_select_i (slave_select),
    .ratio_i        (ratio),
    .status_i       (status),
    .rx_empty_i     (rx_empty),
    .rx_data_i      (rx_data),
    .tx_count_i     (tx_count),
    .rx_count_i     (rx_count),
    .rx_pop_o       (rx_pop)
  );

  spi_core #(
    .DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH), .RATIO_WIDTH(RATIO_WIDTH)
  ) core_i (
    .fixed_clk_i, .axi_aresetn_i,
    .soft_rst_i     (soft_rst),
    .control_i      (control),
    .slave_select_i (slave_select),
    .ratio_i        (ratio),
    .tx_push_i      (tx_push),
    .tx_push_data_i (tx_push_data),
    .tx_clr_i       (tx_clr),
    .rx_pop_i       (rx_pop),
    .rx_clr_i       (rx_clr),
    .status_o       (status),
    .tx_full_o      (tx_full),
    .rx_empty_o     (rx_empty),
    .rx_data_o      (rx_data),
    .tx_count_o     (tx_count),
    .rx_count_o     (rx_count),
    .spi_clk_o, .spi_cs_n_o, .spi_mosi_o, .spi_miso_i
  );

endmodule

// ==== verification/axi_spi_props.sv ====
`timescale 1ns/1ps

module axi_spi_props (
  input logic fixed_clk_i,
  input logic axi_aresetn_i,
  input logic awready_i,
  input logic wready_i,
  input logic bvalid_i,
  input logic bready_i,
  input logic rvalid_i,
  input logic rready_i,
  input logic cs_n_i,
  input logic spe_i
);

  bvalid_hold: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

  aw_w_together: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    awready_i == wready_i)
    else $error("awready and wready differ");

  aw_one_cycle: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    awready_i |=> !awready_i)
    else $error("awready held longer than one cycle");

  // chip select only moves while the core is enabled
  cs_idle: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    !spe_i |-> cs_n_i)
    else $error("spi_cs_n_o low while spe is clear");

endmodule

bind axi_spi_top axi_spi_props props_i (
  .fixed_clk_i, .axi_aresetn_i,
  .awready_i (axi_awready_o),
  .wready_i  (axi_wready_o),
  .bvalid_i  (axi_bvalid_o),
  .bready_i  (axi_bready_i),
  .rvalid_i  (axi_rvalid_o),
  .rready_i  (axi_rready_i),
  .cs_n_i    (spi_cs_n_o),
  .spe_i     (control.f.spe)
);

// ==== verification/axi_spi_tb.sv ====
`timescale 1ns/1ps

module axi_spi_tb;
  import axi_spi_pkg::*;

  localparam int DATA_WIDTH    = 8;
  localparam int FIFO_DEPTH    = 16;
  localparam int RATIO_WIDTH   = 3;
  localparam int CLK_PERIOD    = 8;
  localparam int SEED          = 32'h3331_120c;
  localparam int N_XFERS       = 16; // 4 modes x 2 orders x 2 ratios
  localparam int MAX_XFER_CLKS = DATA_WIDTH * (2 ** (2 ** RATIO_WIDTH));
  localparam int WATCHDOG_NS   = (N_XFERS + 16) * MAX_XFER_CLKS * CLK_PERIOD; // margin

  logic                  fixed_clk_i;
  logic                  axi_aresetn_i;
  axi_addr_t             axi_awaddr_i;
  logic                  axi_awvalid_i;
  logic                  axi_awready_o;
  axi_word_t             axi_wdata_i;
  logic [AXI_STRB_W-1:0] axi_wstrb_i;
  logic                  axi_wvalid_i;
  logic                  axi_wready_o;
  axi_resp_t             axi_bresp_o;
  logic                  axi_bvalid_o;
  logic                  axi_bready_i;
  axi_addr_t             axi_araddr_i;
  logic                  axi_arvalid_i;
  logic                  axi_arready_o;
  axi_word_t             axi_rdata_o;
  axi_resp_t             axi_rresp_o;
  logic                  axi_rvalid_o;
  logic                  axi_rready_i;
  logic                  spi_clk_o;
  logic                  spi_cs_n_o;
  logic                  spi_mosi_o;
  logic                  spi_miso_i;
  string                 test_name;

  axi_spi_top #(
    .DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH), .RATIO_WIDTH(RATIO_WIDTH)
  ) dut_i (.*);

  always #(CLK_PERIOD / 2) fixed_clk_i = ~fixed_clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input string label, input axi_word_t exp, input axi_word_t act);
    if (act !== exp) begin
      report_failure($sformatf("error %s: %s expected 0x%08h, actual 0x%08h",
                               test_name, label, exp, act));
    end
  endtask

  task automatic check_resp(input string label, input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp) begin
      report_failure($sformatf("error %s: %s expected %b, actual %b",
                               test_name, label, exp, act));
    end
  endtask

  task automatic check_byte(input string label, input logic [DATA_WIDTH-1:0] exp,
                            input logic [DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("error %s: %s expected 0x%02h, actual 0x%02h",
                               test_name, label, exp, act));
    end
  endtask

  function automatic axi_word_t strobe_mask(input axi_word_t data,
                                            input logic [AXI_STRB_W-1:0] strb);
    axi_word_t keep;
    keep = '0;
    for (int i = 0; i < AXI_STRB_W; i++) begin
      if (strb[i]) keep[8*i +: 8] = 8'hFF;
    end
    return data & keep;
  endfunction

  // called on a falling edge, returns on a falling edge
  task automatic axi_write(input axi_addr_t addr, input axi_word_t data,
                           input logic [AXI_STRB_W-1:0] strb);
    axi_awaddr_i  = addr;
    axi_wdata_i   = data;
    axi_wstrb_i   = strb;
    axi_awvalid_i = 1'b1;
    axi_wvalid_i  = 1'b1;
    axi_bready_i  = 1'b1;
    do begin
      @(negedge fixed_clk_i);
    end while (!axi_awready_o);
    if (!axi_bvalid_o) report_failure("bvalid was not raised together with awready");
    check_resp($sformatf("bresp at 0x%02h", addr), RESP_OKAY, axi_bresp_o);
    axi_awvalid_i = 1'b0;
    axi_wvalid_i  = 1'b0;
    @(negedge fixed_clk_i);
    axi_bready_i = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_word_t data, output axi_resp_t resp);
    axi_araddr_i  = addr;
    axi_arvalid_i = 1'b1;
    axi_rready_i  = 1'b1;
    do begin
      @(negedge fixed_clk_i);
    end while (!axi_arready_o);
    if (!axi_rvalid_o) report_failure("rvalid was not raised together with arready");
    data          = axi_rdata_o;
    resp          = axi_rresp_o;
    axi_arvalid_i = 1'b0;
    @(negedge fixed_clk_i);
    axi_rready_i = 1'b0;
  endtask

  task automatic expect_read(input axi_addr_t addr, input axi_word_t exp, input string label);
    axi_word_t data;
    axi_resp_t resp;
    axi_read(addr, data, resp);
    check_resp({label, " rresp"}, RESP_OKAY, resp);
    check_word(label, exp, data);
  endtask

  // slave side of one word, standard modes, edges seen through the bus clock
  task automatic slave_exchange(input logic cpha, input logic lsb,
                                input logic [DATA_WIDTH-1:0] miso_byte,
                                output logic [DATA_WIDTH-1:0] mosi_byte);
    int idx;
    mosi_byte = '0;
    @(negedge spi_cs_n_o);
    if (!cpha) begin
      @(negedge fixed_clk_i);
      spi_miso_i = miso_byte[lsb ? 0 : DATA_WIDTH-1]; // first bit before the first edge
    end
    for (int k = 0; k < DATA_WIDTH; k++) begin
      idx = lsb ? k : DATA_WIDTH - 1 - k;
      @(spi_clk_o); // leading edge
      @(negedge fixed_clk_i);
      if (spi_cs_n_o) report_failure("spi_cs_n_o went high in the middle of a transfer");
      if (cpha) spi_miso_i = miso_byte[idx];
      else mosi_byte[idx] = spi_mosi_o;
      @(spi_clk_o); // trailing edge
      @(negedge fixed_clk_i);
      if (cpha) mosi_byte[idx] = spi_mosi_o;
      else if (k < DATA_WIDTH - 1) spi_miso_i = miso_byte[lsb ? idx + 1 : idx - 1];
    end
  endtask

  task automatic wait_rx_data();
    axi_word_t sr;
    axi_resp_t resp;
    do begin
      axi_read(ADDR_SR, sr, resp);
      check_resp("sr poll rresp", RESP_OKAY, resp);
    end while (sr[SR_RX_EMPTY_BIT]);
  endtask

  task automatic expect_reset_state();
    expect_read(ADDR_CR, 32'h0, "cr");
    expect_read(ADDR_SSR, 32'h1, "ssr");
    expect_read(ADDR_RCLK, 32'h0, "rclk");
    expect_read(ADDR_SR, 32'h0000_0005, "sr"); // both fifos empty
    expect_read(ADDR_TFOR, 32'h0, "tfor");
    expect_read(ADDR_RFOR, 32'h0, "rfor");
    expect_read(8'h10, 32'h6162_6364, "unmapped");
  endtask

  task automatic reset_values();
    test_name = "reset_values";
    expect_reset_state();
  endtask

  task automatic byte_strobes();
    axi_word_t             data;
    logic [AXI_STRB_W-1:0] strb;
    axi_word_t             ssr_exp;
    axi_word_t             rclk_exp;
    test_name = "byte_strobes";
    for (int n = 0; n < 8; n++) begin
      data    = $urandom();
      strb    = AXI_STRB_W'($urandom());
      ssr_exp = strobe_mask(data, strb) & 32'h1;
      axi_write(ADDR_SSR, data, strb);
      expect_read(ADDR_SSR, ssr_exp, "ssr");
      data     = $urandom();
      strb     = AXI_STRB_W'($urandom());
      rclk_exp = strobe_mask(data, strb) & ((32'h1 << RATIO_WIDTH) - 1);
      axi_write(ADDR_RCLK, data, strb);
      expect_read(ADDR_RCLK, rclk_exp, "rclk");
      axi_write(8'h10, $urandom(), 4'hF); // hole in the map
      expect_read(ADDR_SSR, ssr_exp, "ssr after unmapped write");
      expect_read(ADDR_RCLK, rclk_exp, "rclk after unmapped write");
    end
  endtask

  task automatic fifo_occupancy();
    test_name = "fifo_occupancy";
    axi_write(ADDR_CR, 32'h0, 4'hF);
    repeat (3) axi_write(ADDR_DTR, $urandom(), 4'hF);
    expect_read(ADDR_TFOR, 32'h3, "tfor after three pushes");
    expect_read(ADDR_SR, 32'h0000_0001, "sr with tx data");
    axi_write(ADDR_CR, 32'h0000_0044, 4'hF); // rx fifo reset only
    expect_read(ADDR_TFOR, 32'h3, "tfor after rx clear");
    axi_write(ADDR_CR, 32'h0000_0064, 4'hF); // both fifo resets, master
    expect_read(ADDR_TFOR, 32'h0, "tfor after clear");
    expect_read(ADDR_CR, 32'h0000_0004, "cr after clear");
    expect_read(ADDR_SR, 32'h0000_0005, "sr after clear");
  endtask

  task automatic spi_transfers();
    logic [DATA_WIDTH-1:0] tx_byte;
    logic [DATA_WIDTH-1:0] miso_byte;
    logic [DATA_WIDTH-1:0] seen_byte;
    axi_word_t             cr_word;
    test_name = "spi_transfers";
    axi_write(ADDR_SSR, 32'h0, 4'hF);
    for (int r = 0; r <= 2; r += 2) begin
      for (int mode = 0; mode < 4; mode++) begin
        for (int lsb = 0; lsb < 2; lsb++) begin
          cr_word    = 32'h0000_0006; // spe and master
          cr_word[3] = mode[1];       // cpol
          cr_word[4] = mode[0];       // cpha
          cr_word[9] = lsb[0];
          tx_byte    = DATA_WIDTH'($urandom());
          miso_byte  = DATA_WIDTH'($urandom());
          axi_write(ADDR_RCLK, r, 4'hF);
          axi_write(ADDR_CR, cr_word, 4'hF);
          fork
            slave_exchange(mode[0], lsb[0], miso_byte, seen_byte);
            begin
              axi_write(ADDR_DTR, axi_word_t'(tx_byte), 4'hF);
              wait_rx_data();
            end
          join
          check_byte($sformatf("mosi mode %0d lsb %0d ratio %0d", mode, lsb, r),
                     tx_byte, seen_byte);
          expect_read(ADDR_DRR, axi_word_t'(miso_byte),
                      $sformatf("drr mode %0d lsb %0d ratio %0d", mode, lsb, r));
        end
      end
    end
    axi_write(ADDR_CR, 32'h0, 4'hF);
  endtask

  task automatic soft_reset();
    test_name = "soft_reset";
    axi_write(ADDR_CR, 32'h0000_0204, 4'hF); // master, lsb first, spe clear
    axi_write(ADDR_SSR, 32'h0, 4'hF);
    axi_write(ADDR_RCLK, 32'h5, 4'hF);
    repeat (2) axi_write(ADDR_DTR, $urandom(), 4'hF);
    axi_write(ADDR_SRR, 32'h0000_0005, 4'hF); // wrong key
    expect_read(ADDR_CR, 32'h0000_0204, "cr after wrong key");
    expect_read(ADDR_SSR, 32'h0, "ssr after wrong key");
    expect_read(ADDR_RCLK, 32'h5, "rclk after wrong key");
    expect_read(ADDR_TFOR, 32'h2, "tfor after wrong key");
    axi_write(ADDR_SRR, SRR_KEY, 4'hF);
    expect_reset_state();
  endtask

  initial begin
    void'($urandom(SEED));
    fixed_clk_i   = 1'b0;
    axi_aresetn_i = 1'b0;
    axi_awaddr_i  = '0;
    axi_awvalid_i = 1'b0;
    axi_wdata_i   = '0;
    axi_wstrb_i   = '0;
    axi_wvalid_i  = 1'b0;
    axi_bready_i  = 1'b0;
    axi_araddr_i  = '0;
    axi_arvalid_i = 1'b0;
    axi_rready_i  = 1'b0;
    spi_miso_i    = 1'b0;
    test_name     = "startup";
    repeat (3) @(posedge fixed_clk_i);
    @(negedge fixed_clk_i);
    axi_aresetn_i = 1'b1;
    @(negedge fixed_clk_i);
    reset_values();
    byte_strobes();
    fifo_occupancy();
    spi_transfers();
    soft_reset();
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("timeout: the tests did not finish in the expected time");
  end

endmodule

// ==== axi_spi.f ====
source/axi_spi_pkg.sv
source/axi_spi_wr_ctrl.sv
source/axi_spi_rd_ctrl.sv
source/spi_fifo.sv
source/spi_shifter.sv
source/spi_core.sv
source/axi_spi_top.sv
verification/axi_spi_props.sv
verification/axi_spi_tb.sv
